// ==== logic/bpsk_config.svh ====
`ifndef BPSK_CONFIG_SVH
`define BPSK_CONFIG_SVH

// bits per data word, sent msb first.
`define BPSK_WORD_BITS 8

// samples per bit, one full carrier period per symbol.
// keep this even, the 180 degree offset is wavelength / 2.
`define BPSK_WAVELENGTH 16

// signed sample width on the output.
`define BPSK_SAMPLE_WIDTH 16

`endif

// ==== logic/bpsk_pkg.sv ====
`include "bpsk_config.svh"

package bpsk_pkg;

    localparam int PHASE_BITS = $clog2(`BPSK_WAVELENGTH); // index into one period.
    localparam int BIT_IDX_BITS = $clog2(`BPSK_WORD_BITS); // index into the word.
    localparam real PI = 3.14159265358979;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_t;

    typedef logic signed [`BPSK_SAMPLE_WIDTH-1:0] sample_value_t;

    typedef struct packed {
        logic active; // produce a sample this cycle.
        logic [PHASE_BITS-1:0] phase; // sample index within the bit.
        logic last; // final sample of the frame.
    } carrier_ctrl_t;

    typedef struct packed {
        logic valid;
        logic last;
        sample_value_t value;
    } sample_t;

    typedef sample_value_t sine_table_t [`BPSK_WAVELENGTH];

    // one sine period, rounded to nearest, peak one lsb below full scale
    function automatic sine_table_t build_sine_table();
        sine_table_t tbl;
        real amp;
        real angle;
        real val;
        amp = real'((1 << (`BPSK_SAMPLE_WIDTH - 1)) - 1);
        for (int i = 0; i < `BPSK_WAVELENGTH; i++) begin
            angle = 2.0 * PI * real'(i) / real'(`BPSK_WAVELENGTH);
            val = amp * $sin(angle);
            tbl[i] = sample_value_t'($rtoi((val >= 0.0) ? (val + 0.5) : (val - 0.5)));
        end
        return tbl;
    endfunction

    localparam sine_table_t SINE_TABLE = build_sine_table();

endpackage

// ==== logic/word_serializer.sv ====
`timescale 1ns/1ns
`include "bpsk_config.svh"

module word_serializer (
    input  logic clk,
    input  logic reset_local,
    input  logic load,
    input  logic shift,
    input  logic [`BPSK_WORD_BITS-1:0] word,
    output logic serial_bit
);

    logic [`BPSK_WORD_BITS-1:0] shift_reg; // word in flight, msb first.

    always_ff @(posedge clk) begin
        if (reset_local) begin
            shift_reg <= '0;
        end else if (load) begin
            shift_reg <= word;
        end else if (shift) begin
            shift_reg <= {shift_reg[`BPSK_WORD_BITS-2:0], 1'b0}; // next bit to the top.
        end
    end

    assign serial_bit = shift_reg[`BPSK_WORD_BITS-1]; // msb is the current symbol.

    // the sequencer loads only in idle and shifts only mid-frame
    load_shift_exclusive: assert property (
        @(posedge clk) disable iff (reset_local)
        !(load && shift)
    ) else $error("word_serializer: load and shift high together.");

endmodule

// ==== logic/symbol_sequencer.sv ====
`timescale 1ns/1ns
`include "bpsk_config.svh"

module symbol_sequencer (
    input  logic clk,
    input  logic reset_local,
    input  logic start,
    output logic load,
    output logic shift,
    output bpsk_pkg::carrier_ctrl_t ctrl,
    output logic busy
);

    bpsk_pkg::seq_state_t state;
    logic [bpsk_pkg::PHASE_BITS-1:0] phase_cnt;
    logic [bpsk_pkg::BIT_IDX_BITS-1:0] bit_cnt;
    bpsk_pkg::carrier_ctrl_t ctrl_q; // counters delayed one cycle, behind the load edge.
    logic phase_wrap;
    logic final_sample;

    assign phase_wrap = (int'(phase_cnt) == `BPSK_WAVELENGTH - 1);
    assign final_sample = (state == bpsk_pkg::SEQ_RUN) && phase_wrap
                          && (int'(bit_cnt) == `BPSK_WORD_BITS - 1);

    assign load = start && (state == bpsk_pkg::SEQ_IDLE); // start is dropped while running.
    assign busy = (state == bpsk_pkg::SEQ_RUN);
    assign ctrl = ctrl_q;

    // shift on the delayed phase so serial_bit turns over with the ROM's bit boundary
    assign shift = ctrl_q.active && (int'(ctrl_q.phase) == `BPSK_WAVELENGTH - 1)
                   && !ctrl_q.last;

    always_ff @(posedge clk) begin
        if (reset_local) begin
            state <= bpsk_pkg::SEQ_IDLE;
            phase_cnt <= '0;
            bit_cnt <= '0;
            ctrl_q <= '0;
        end else begin
            ctrl_q.active <= (state == bpsk_pkg::SEQ_RUN);
            ctrl_q.phase <= phase_cnt;
            ctrl_q.last <= final_sample;

            case (state)
                bpsk_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state <= bpsk_pkg::SEQ_RUN;
                        phase_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                bpsk_pkg::SEQ_RUN: begin
                    if (phase_wrap) begin
                        phase_cnt <= '0;
                        if (final_sample) begin
                            state <= bpsk_pkg::SEQ_IDLE;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1; // next symbol.
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                default: state <= bpsk_pkg::SEQ_IDLE;
            endcase
        end
    end

    load_from_idle: assert property (
        @(posedge clk) disable iff (reset_local)
        load |-> (state == bpsk_pkg::SEQ_IDLE) ##1 (state == bpsk_pkg::SEQ_RUN)
    ) else $error("symbol_sequencer: load outside idle.");

    phase_in_range: assert property (
        @(posedge clk) disable iff (reset_local)
        int'(phase_cnt) < `BPSK_WAVELENGTH
    ) else $error("symbol_sequencer: phase counter out of range.");

    // a frame always ends with at least one idle ctrl cycle before the next one.
    last_is_active: assert property (
        @(posedge clk) disable iff (reset_local)
        ctrl.last |-> ctrl.active ##1 !ctrl.active
    ) else $error("symbol_sequencer: last without active.");

endmodule

// ==== logic/carrier_rom.sv ====
`timescale 1ns/1ns
`include "bpsk_config.svh"

module carrier_rom (
    input  logic clk,
    input  logic reset_local,
    input  bpsk_pkg::carrier_ctrl_t ctrl,
    input  logic serial_bit,
    output bpsk_pkg::sample_t sample
);

    localparam int HALF = `BPSK_WAVELENGTH / 2;
    localparam logic [bpsk_pkg::PHASE_BITS-1:0] HALF_PHASE = HALF[bpsk_pkg::PHASE_BITS-1:0];

    logic [bpsk_pkg::PHASE_BITS-1:0] table_index;

    // a 0 bit reads half a period ahead, wrapped without a modulo
    always_comb begin
        if (serial_bit) begin
            table_index = ctrl.phase; // in phase.
        end else if (int'(ctrl.phase) >= HALF) begin
            table_index = ctrl.phase - HALF_PHASE;
        end else begin
            table_index = ctrl.phase + HALF_PHASE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_local) begin
            sample <= '0;
        end else if (ctrl.active) begin
            sample.valid <= 1'b1;
            sample.last <= ctrl.last;
            sample.value <= bpsk_pkg::SINE_TABLE[table_index];
        end else begin
            sample <= '0; // quiet line between frames.
        end
    end

    last_implies_valid: assert property (
        @(posedge clk) disable iff (reset_local)
        sample.last |-> sample.valid
    ) else $error("carrier_rom: sample.last without sample.valid.");

endmodule

// ==== logic/bpsk_modulator.sv ====
`timescale 1ns/1ns
`include "bpsk_config.svh"

module bpsk_modulator (
    input  logic clk,
    input  logic reset_local,
    input  logic start,
    input  logic [`BPSK_WORD_BITS-1:0] word,
    output logic busy,
    output bpsk_pkg::sample_t sample
);

    logic load;
    logic shift;
    logic serial_bit;
    bpsk_pkg::carrier_ctrl_t ctrl;

    word_serializer word_serializer_inst (
        .clk        (clk),
        .reset_local(reset_local),
        .load       (load),
        .shift      (shift),
        .word       (word),
        .serial_bit (serial_bit)
    );

    symbol_sequencer symbol_sequencer_inst (
        .clk        (clk),
        .reset_local(reset_local),
        .start      (start),
        .load       (load),
        .shift      (shift),
        .ctrl       (ctrl),
        .busy       (busy)
    );

    carrier_rom carrier_rom_inst ( // registers the output sample.
        .clk        (clk),
        .reset_local(reset_local),
        .ctrl       (ctrl),
        .serial_bit (serial_bit),
        .sample     (sample)
    );

endmodule

// ==== verification/bpsk_modulator_tb.sv ====
`timescale 1ns/1ns
`include "bpsk_config.svh"

module bpsk_modulator_tb;

    localparam int FRAME_LEN = `BPSK_WORD_BITS * `BPSK_WAVELENGTH; // samples per frame.
    localparam int WAIT_LIMIT = 64;
    localparam int WATCHDOG_NS = 200000;
    localparam logic [31:0] SEED = 32'hb2e6_360a;

    logic clk;
    logic reset_local;
    logic start;
    logic [`BPSK_WORD_BITS-1:0] word;
    logic busy;
    bpsk_pkg::sample_t sample;
    logic [31:0] rng_state;

    bpsk_modulator bpsk_modulator_inst (
        .clk        (clk),
        .reset_local(reset_local),
        .start      (start),
        .word       (word),
        .busy       (busy),
        .sample     (sample)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("simulation ran past its time limit");
    end

    task automatic fail_run(input string reason);
        $display("Errors found");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // bit i of the frame picks the in-phase or half-period-shifted table entry.
    function automatic bpsk_pkg::sample_value_t reference_value(
        input logic [`BPSK_WORD_BITS-1:0] w,
        input int index
    );
        int bit_pos;
        int phase;
        int table_idx;
        bit_pos = index / `BPSK_WAVELENGTH;
        phase = index % `BPSK_WAVELENGTH;
        if (w[`BPSK_WORD_BITS-1-bit_pos]) begin
            table_idx = phase;
        end else begin
            table_idx = (phase + `BPSK_WAVELENGTH / 2) % `BPSK_WAVELENGTH;
        end
        return bpsk_pkg::SINE_TABLE[table_idx];
    endfunction

    task automatic compare_sample(input string test_name, input bpsk_pkg::sample_t expected,
                                  input bpsk_pkg::sample_t actual);
        string expected_text;
        string actual_text;
        if (actual !== expected) begin
            expected_text = $sformatf("valid=%b last=%b value=%0d", expected.valid,
                                      expected.last, expected.value);
            actual_text = $sformatf("valid=%b last=%b value=%0d", actual.valid,
                                    actual.last, actual.value);
            $display("[ERROR] %s: expected %s, actual %s", test_name, expected_text, actual_text);
            fail_run("sample mismatch");
        end
    endtask

    task automatic compare_bit(input string test_name, input string what,
                               input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %b actual %b", test_name, what, expected, actual);
            fail_run("flag mismatch");
        end
    endtask

    task automatic compare_count(input string test_name, input string what,
                                 input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            fail_run("count mismatch");
        end
    endtask

    // start is sampled by the DUT on the edge after the one that drives it.
    task automatic drive_start(input logic [`BPSK_WORD_BITS-1:0] w);
        @(posedge clk);
        start <= 1'b1;
        word <= w;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_valid(input string test_name, output int waited);
        waited = 0;
        while (1) begin
            @(negedge clk);
            waited++;
            if (sample.valid) break;
            if (waited >= WAIT_LIMIT) begin
                fail_run({test_name, ": no valid sample arrived in time"});
            end
        end
    endtask

    task automatic check_idle(input string test_name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_bit(test_name, "busy", 1'b0, busy);
            compare_sample(test_name, '0, sample);
        end
    endtask

    // entered on the first valid sample; may strobe start mid-frame.
    task automatic collect_frame(input string test_name, input logic [`BPSK_WORD_BITS-1:0] w,
                                 input int strobe_at,
                                 input logic [`BPSK_WORD_BITS-1:0] strobe_word,
                                 input logic chained);
        bpsk_pkg::sample_t expected;
        for (int i = 0; i < FRAME_LEN; i++) begin
            if (i > 0) @(negedge clk);
            expected.valid = 1'b1;
            expected.last = (i == FRAME_LEN - 1);
            expected.value = reference_value(w, i);
            compare_sample(test_name, expected, sample);
            if (i == strobe_at) begin
                @(posedge clk);
                start <= 1'b1;
                word <= strobe_word;
            end else if (strobe_at >= 0 && i == strobe_at + 1) begin
                compare_bit(test_name, "busy", !chained, busy); // first idle cycle when chained.
                @(posedge clk);
                start <= 1'b0;
            end
        end
        if (chained) begin
            compare_bit(test_name, "busy", 1'b1, busy); // next frame accepted.
        end else begin
            @(negedge clk);
            compare_bit(test_name, "busy", 1'b0, busy);
            compare_sample(test_name, '0, sample);
        end
    endtask

    task automatic test_reset_state();
        check_idle("reset_state", 20);
    endtask

    task automatic test_single_frame();
        int waited;
        drive_start(8'hA5);
        wait_for_valid("single_frame", waited);
        compare_count("single_frame", "cycles to first sample", 3, waited);
        collect_frame("single_frame", 8'hA5, -1, '0, 1'b0);
        check_idle("single_frame", 4);
    endtask

    task automatic test_constant_words();
        int waited;
        drive_start(8'h00);
        wait_for_valid("constant_zero", waited);
        collect_frame("constant_zero", 8'h00, -1, '0, 1'b0); // shifted table on every bit.
        drive_start(8'hFF);
        wait_for_valid("constant_one", waited);
        collect_frame("constant_one", 8'hFF, -1, '0, 1'b0);
    endtask

    task automatic test_start_while_busy();
        int waited;
        drive_start(8'h3C);
        wait_for_valid("start_while_busy", waited);
        collect_frame("start_while_busy", 8'h3C, FRAME_LEN / 2, 8'hC3, 1'b0);
        check_idle("start_while_busy", 2 * `BPSK_WAVELENGTH); // no second frame.
    endtask

    task automatic test_back_to_back();
        logic [`BPSK_WORD_BITS-1:0] words [4];
        int waited;
        rng_state = SEED;
        for (int k = 0; k < 4; k++) begin
            rng_state = next_random(rng_state);
            words[k] = rng_state[`BPSK_WORD_BITS-1:0];
        end
        drive_start(words[0]);
        for (int k = 0; k < 4; k++) begin
            wait_for_valid("back_to_back", waited);
            if (k < 3) begin
                collect_frame("back_to_back", words[k], FRAME_LEN - 3, words[k+1], 1'b1);
            end else begin
                collect_frame("back_to_back", words[k], -1, '0, 1'b0);
            end
        end
        check_idle("back_to_back", 8);
    endtask

    initial begin
        reset_local = 1'b1;
        start = 1'b0;
        word = '0;
        repeat (5) @(posedge clk);
        reset_local <= 1'b0;
        test_reset_state();
        test_single_frame();
        test_constant_words();
        test_start_while_busy();
        test_back_to_back();
        $display("No errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/bpsk_pkg.sv
logic/word_serializer.sv
logic/symbol_sequencer.sv
logic/carrier_rom.sv
logic/bpsk_modulator.sv
verification/bpsk_modulator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the BPSK modulator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --timescale 1ns/1ns \
    --top-module bpsk_modulator_tb \
    -Mdir obj_dir \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit "$status"
fi

./obj_dir/Vbpsk_modulator_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
